// ==== hw/i2cPkg.sv ====
// APB request/response structs, FIFO item structs, register map and field positions
package i2cPkg;

	// --------------------
	// APB bus
	// --------------------
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;
	} apbRspT;

	// --------------------
	// FIFO items
	// --------------------
	typedef struct packed {
		logic       readDir;    // Slave drives this byte
		logic [7:0] data;
	} txItemT;

	typedef struct packed {
		logic [7:0] index;      // Byte position in transaction
		logic [7:0] data;
	} rxItemT;

	// --------------------
	// Register map
	// --------------------
	localparam logic [7:0] regCtrl   = 8'h00;
	localparam logic [7:0] regDiv    = 8'h04;
	localparam logic [7:0] regStatus = 8'h08;
	localparam logic [7:0] regTxData = 8'h0C;
	localparam logic [7:0] regRxData = 8'h10;

	// Control fields
	localparam int ctrlStartBit = 0;
	localparam int ctrlLenLsb   = 8;
	localparam int ctrlIntEnBit = 16;

	// Status fields
	localparam int statBusyBit  = 0;
	localparam int statDoneBit  = 1;    // Sticky, W1C
	localparam int statOvfBit   = 2;    // Sticky, W1C
	localparam int statTxLvlLsb = 8;
	localparam int statRxLvlLsb = 16;

endpackage

// ==== hw/i2cApbRegs.sv ====
// APB slave register block: control, divisor, status, FIFO push/pop and interrupt
`timescale 1ns/1ps

module i2cApbRegs #(
	parameter int fifoDepth = 16
) (
	input  logic                           iSysClk,
	input  logic                           arstN,
	input  i2cPkg::apbReqT                 apbReq,
	output i2cPkg::apbRspT                 apbRsp,
	output logic                           txPush,
	output i2cPkg::txItemT                 txItem,
	input  logic                           txFull,
	input  logic [$clog2(fifoDepth+1)-1:0] txLevel,
	output logic                           rxPop,
	input  i2cPkg::rxItemT                 rxItem,
	input  logic                           rxEmpty,
	input  logic                           rxFull,
	input  logic [$clog2(fifoDepth+1)-1:0] rxLevel,
	output logic                           start,
	output logic [7:0]                     length,
	output logic [15:0]                    divisor,
	input  logic                           busy,
	input  logic                           done,
	output logic                           irq
);
	import i2cPkg::*;

	logic        acc;          // Access phase
	logic        wrAcc;
	logic        rdAcc;
	logic        mapped;
	logic        startErr;     // Start while engine active
	logic        txErr;        // Push into full tx FIFO
	logic        rxErr;        // Pop from empty rx FIFO
	logic        intEn;
	logic        doneS;
	logic        ovfS;
	logic [31:0] rdData;

	// --------------------
	// Transfer decode
	// --------------------
	assign acc   = apbReq.psel & apbReq.penable;
	assign wrAcc = acc & apbReq.pwrite;
	assign rdAcc = acc & ~apbReq.pwrite;

	assign startErr = wrAcc && (apbReq.paddr == regCtrl) && apbReq.pwdata[ctrlStartBit]
		&& (busy || start);
	assign txErr    = wrAcc && (apbReq.paddr == regTxData) && txFull;
	assign rxErr    = rdAcc && (apbReq.paddr == regRxData) && rxEmpty;

	// FIFO strobes, full/empty already filtered here
	assign txPush = wrAcc && (apbReq.paddr == regTxData) && !txFull;
	assign txItem = txItemT'(apbReq.pwdata[8:0]);     // readDir in bit 8
	assign rxPop  = rdAcc && (apbReq.paddr == regRxData) && !rxEmpty;

	// Zero wait states
	assign apbRsp.pready  = acc;
	assign apbRsp.prdata  = rdData;
	assign apbRsp.pslverr = acc && (!mapped || startErr || txErr || rxErr);

	assign irq = doneS & intEn;    // Level while done pending

	// --------------------
	// Read mux
	// --------------------
	always_comb
	begin
		mapped = 1'b1;
		rdData = '0;
		case (apbReq.paddr)
			regCtrl:
				rdData = {15'd0, intEn, length, 7'd0, start};
			regDiv:
				rdData = {16'd0, divisor};
			regStatus:
			begin
				rdData[statBusyBit]               = busy;
				rdData[statDoneBit]               = doneS;
				rdData[statOvfBit]                = ovfS;
				rdData[statTxLvlLsb +: 8]         = 8'(txLevel);
				rdData[statRxLvlLsb +: 8]         = 8'(rxLevel);
			end
			regTxData:
				rdData = '0;                       // Write-only
			regRxData:
				rdData = rxEmpty ? '0 : 32'(rxItem);   // FWFT head, same cycle
			default:
				mapped = 1'b0;
		endcase
	end

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			start   <= 1'b0;
			length  <= '0;
			intEn   <= 1'b0;
			divisor <= 16'd250;
			doneS   <= 1'b0;
			ovfS    <= 1'b0;
		end
		else
		begin
			start <= 1'b0;                     // One-cycle pulse
			if (wrAcc)
			begin
				case (apbReq.paddr)
					regCtrl:
						if (!startErr)             // Whole write dropped on error
						begin
							intEn  <= apbReq.pwdata[ctrlIntEnBit];
							length <= apbReq.pwdata[ctrlLenLsb +: 8];
							start  <= apbReq.pwdata[ctrlStartBit];
						end
					regDiv:
						divisor <= apbReq.pwdata[15:0];
					regStatus:
					begin
						if (apbReq.pwdata[statDoneBit])
							doneS <= 1'b0;
						if (apbReq.pwdata[statOvfBit])
							ovfS <= 1'b0;
					end
					default: ;
				endcase
			end
			// Sets take priority over W1C
			if (done)
				doneS <= 1'b1;
			if (rxFull)
				ovfS <= 1'b1;
		end
	end

	// Start pulse must only ever reach an idle engine
	aNoStartBusy : assert property (@(posedge iSysClk) disable iff (!arstN)
		start |-> !busy);

endmodule

// ==== hw/i2cSyncFifo.sv ====
// Synchronous first-word-fall-through FIFO, item type set by parameter
`timescale 1ns/1ps

module i2cSyncFifo #(
	parameter int  fifoDepth = 16,
	parameter type itemT     = logic [7:0]
) (
	input  logic                           iSysClk,
	input  logic                           arstN,
	input  logic                           push,
	input  itemT                           pushItem,
	input  logic                           pop,
	output itemT                           popItem,
	output logic                           full,
	output logic                           empty,
	output logic [$clog2(fifoDepth+1)-1:0] level
);

	localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

	itemT            mem [fifoDepth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;

	assign full    = (level == fifoDepth);
	assign empty   = (level == '0);
	assign popItem = mem[rdPtr];       // Head visible without pop

	// Storage, no reset
	always_ff @(posedge iSysClk)
	begin
		if (push)
			mem[wrPtr] <= pushItem;
	end

	// Pointers and count
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Callers filter full/empty upstream
	aNoPushFull : assert property (@(posedge iSysClk) disable iff (!arstN)
		push |-> !full);
	aNoPopEmpty : assert property (@(posedge iSysClk) disable iff (!arstN)
		pop |-> !empty);

endmodule

// ==== hw/i2cClkDiv.sv ====
// Programmable divider producing the SCL edge enable
`timescale 1ns/1ps

module i2cClkDiv (
	input  logic        iSysClk,
	input  logic        arstN,
	input  logic        run,
	input  logic [15:0] divisor,
	output logic        tick
);

	logic [15:0] cnt;
	logic        wrap;

	// Period of divisor cycles, 0 and 1 both give every cycle
	assign wrap = ({1'b0, cnt} + 17'd1) >= {1'b0, divisor};

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else if (!run)
		begin
			cnt  <= '0;                    // Idle, restart full period
			tick <= 1'b0;
		end
		else
		begin
			tick <= wrap;
			cnt  <= wrap ? '0 : cnt + 1'b1;
		end
	end

endmodule

// ==== hw/i2cByteEngine.sv ====
// I2C byte engine: START/STOP sequencing, bit timing, SDA hold, byte counting
`timescale 1ns/1ps

module i2cByteEngine #(
	parameter int sdaHoldCyc  = 35,
	parameter int stopHoldCyc = 250
) (
	input  logic           iSysClk,
	input  logic           arstN,
	input  logic           tick,
	input  logic           start,
	input  logic [7:0]     length,
	input  i2cPkg::txItemT txItem,
	input  logic           txEmpty,
	output logic           txPop,
	output logic           rxPush,
	output i2cPkg::rxItemT rxItem,
	output logic           busy,
	output logic           done,
	output logic           scl,
	output logic           sdaOe,
	input  logic           sda
);
	import i2cPkg::*;

	localparam int holdW = $clog2(sdaHoldCyc + 1);
	localparam int stopW = $clog2(stopHoldCyc + 1);

	typedef enum logic [2:0] {
		stIdle,
		stStart,
		stData,
		stStop,
		stStopHold
	} stateT;

	stateT            state;
	logic             sclR;
	logic             sdaOeR;             // 1 = SDA pulled low
	logic [3:0]       slotCnt;            // 0..7 data, 8 ACK
	logic [7:0]       byteCnt;
	logic [7:0]       lenR;
	logic [holdW-1:0] holdCnt;
	logic [stopW-1:0] stopCnt;
	logic [7:0]       shiftRx;
	txItemT           curItem;
	logic             sdaUpd;
	logic             sclRise;
	logic             lastSlot;
	logic             lastByte;
	logic             slotPull;

	// --------------------
	// Slot decode
	// --------------------
	// Empty tx FIFO falls back to a 0xFF write byte
	assign curItem  = txEmpty ? txItemT'{readDir: 1'b0, data: 8'hFF} : txItem;
	assign lastSlot = (slotCnt == 4'd8);
	assign lastByte = ((byteCnt + 8'd1) == lenR);
	assign sdaUpd   = (holdCnt == holdW'(1));     // Hold expires next edge
	assign sclRise  = tick && !sclR && (holdCnt == '0)
		&& ((state == stData) || (state == stStop));

	always_comb
	begin
		if (lastSlot)
			slotPull = curItem.readDir;            // Master ACK on read bytes
		else
			slotPull = !curItem.readDir && !curItem.data[3'd7 - slotCnt[2:0]];   // MSB first
	end

	assign busy  = (state != stIdle);
	assign scl   = sclR;
	assign sdaOe = sdaOeR;

	// --------------------
	// Control FSM
	// --------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= stIdle;
			sclR    <= 1'b1;
			sdaOeR  <= 1'b0;
			slotCnt <= '0;
			byteCnt <= '0;
			lenR    <= '0;
			holdCnt <= '0;
			stopCnt <= '0;
			txPop   <= 1'b0;
			rxPush  <= 1'b0;
			done    <= 1'b0;
		end
		else
		begin
			txPop  <= 1'b0;
			rxPush <= 1'b0;
			done   <= 1'b0;
			if (holdCnt != '0)
				holdCnt <= holdCnt - 1'b1;
			case (state)
				stIdle:
					if (start)
					begin
						state   <= stStart;
						sdaOeR  <= 1'b1;           // START, SDA falls with SCL high
						lenR    <= length;
						byteCnt <= '0;
						slotCnt <= '0;
					end
				stStart:
					if (tick)
					begin
						sclR    <= 1'b0;
						holdCnt <= holdW'(sdaHoldCyc);
						state   <= stData;
					end
				stData:
				begin
					if (sdaUpd)
						sdaOeR <= slotPull;
					if (sclRise)
					begin
						sclR <= 1'b1;
						rxPush <= curItem.readDir && lastSlot;   // Push at ACK slot
					end
					else if (tick && sclR)
					begin
						sclR    <= 1'b0;
						holdCnt <= holdW'(sdaHoldCyc);
						if (lastSlot)
						begin
							slotCnt <= '0;
							byteCnt <= byteCnt + 1'b1;
							txPop   <= !txEmpty;
							if (lastByte)
								state <= stStop;
						end
						else
							slotCnt <= slotCnt + 1'b1;
					end
				end
				stStop:
				begin
					if (sdaUpd)
						sdaOeR <= 1'b1;            // Low ahead of STOP
					if (sclRise)
						sclR <= 1'b1;
					else if (tick && sclR)
					begin
						sdaOeR  <= 1'b0;           // STOP, SDA rises with SCL high
						stopCnt <= '0;
						state   <= stStopHold;
					end
				end
				stStopHold:
					if (stopCnt == stopW'(stopHoldCyc - 1))
					begin
						done  <= 1'b1;
						state <= stIdle;
					end
					else
						stopCnt <= stopCnt + 1'b1;
				default:
					state <= stIdle;
			endcase
		end
	end

	// --------------------
	// Receive datapath
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (sclRise && (state == stData) && curItem.readDir)
		begin
			if (!lastSlot)
				shiftRx <= {shiftRx[6:0], sda};    // Sample on SCL rise
			else
				rxItem <= '{index: byteCnt, data: shiftRx};
		end
	end

	// SDA only moves under high SCL at START or STOP
	aSdaStable : assert property (@(posedge iSysClk) disable iff (!arstN)
		(sclR && $past(sclR) && (sdaOeR != $past(sdaOeR)))
			|-> ((state == stStart) || (state == stStopHold)));

endmodule

// ==== hw/i2cTop.sv ====
// I2C master top: register block, tx/rx FIFOs, clock divider and byte engine
`timescale 1ns/1ps

module i2cTop #(
	parameter int fifoDepth   = 16,
	parameter int sdaHoldCyc  = 35,
	parameter int stopHoldCyc = 250
) (
	input  logic           iSysClk,
	input  logic           arstN,
	input  i2cPkg::apbReqT apbReq,
	output i2cPkg::apbRspT apbRsp,
	output logic           irq,
	output logic           scl,
	output logic           sdaOe,
	input  logic           sda
);
	import i2cPkg::*;

	localparam int lvlW = $clog2(fifoDepth + 1);

	// --------------------
	// Interconnect
	// --------------------
	txItemT            txPushItem;
	txItemT            txHead;
	rxItemT            rxPushItem;
	rxItemT            rxHead;
	logic              txPush;
	logic              txPop;
	logic              txFull;
	logic              txEmpty;
	logic [lvlW-1:0]   txLevel;
	logic              rxPush;
	logic              rxPushOk;     // Dropped when rx FIFO full
	logic              rxPop;
	logic              rxFull;
	logic              rxEmpty;
	logic [lvlW-1:0]   rxLevel;
	logic              start;
	logic [7:0]        length;
	logic [15:0]       divisor;
	logic              busy;
	logic              done;
	logic              tick;

	assign rxPushOk = rxPush & ~rxFull;

	i2cApbRegs #(
		.fifoDepth (fifoDepth)
	) i_i2cApbRegs (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.txPush  (txPush),
		.txItem  (txPushItem),
		.txFull  (txFull),
		.txLevel (txLevel),
		.rxPop   (rxPop),
		.rxItem  (rxHead),
		.rxEmpty (rxEmpty),
		.rxFull  (rxFull),
		.rxLevel (rxLevel),
		.start   (start),
		.length  (length),
		.divisor (divisor),
		.busy    (busy),
		.done    (done),
		.irq     (irq)
	);

	i2cSyncFifo #(
		.fifoDepth (fifoDepth),
		.itemT     (txItemT)
	) i_txFifo (
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.push     (txPush),
		.pushItem (txPushItem),
		.pop      (txPop),
		.popItem  (txHead),
		.full     (txFull),
		.empty    (txEmpty),
		.level    (txLevel)
	);

	i2cSyncFifo #(
		.fifoDepth (fifoDepth),
		.itemT     (rxItemT)
	) i_rxFifo (
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.push     (rxPushOk),
		.pushItem (rxPushItem),
		.pop      (rxPop),
		.popItem  (rxHead),
		.full     (rxFull),
		.empty    (rxEmpty),
		.level    (rxLevel)
	);

	// Divider paced by engine activity
	i2cClkDiv i_i2cClkDiv (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.run     (busy),
		.divisor (divisor),
		.tick    (tick)
	);

	i2cByteEngine #(
		.sdaHoldCyc  (sdaHoldCyc),
		.stopHoldCyc (stopHoldCyc)
	) i_i2cByteEngine (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.tick    (tick),
		.start   (start),
		.length  (length),
		.txItem  (txHead),
		.txEmpty (txEmpty),
		.txPop   (txPop),
		.rxPush  (rxPush),
		.rxItem  (rxPushItem),
		.busy    (busy),
		.done    (done),
		.scl     (scl),
		.sdaOe   (sdaOe),
		.sda     (sda)
	);

endmodule

// ==== dv/i2cSlaveModel.sv ====
// I2C slave model: START/STOP detection, write byte log, read byte table, SDA rule check
`timescale 1ns/1ps

module i2cSlaveModel (
	input  logic         iSysClk,
	input  logic         arstN,
	input  logic         scl,
	input  logic         sda,          // Resolved bus level
	input  logic [31:0]  readMask,     // Bit k set, slave sends byte k
	input  logic [255:0] rdTable,      // Byte k in bits 8k+7:8k
	output logic         sdaPull       // Slave pulls SDA low
);

	// --------------------
	// Logs for the testbench
	// --------------------
	logic [7:0] wrLog [32];            // Master-written bytes, last transaction
	logic       ackLog [32];           // ACK slot seen low, by byte index
	int         wrCnt;
	int         startCnt;
	int         stopCnt;
	int         ruleErrCnt;            // Bad SDA move under high SCL

	logic       sclQ;
	logic       sdaQ;
	logic       inXfer;
	int         bitCnt;                // 0..7 data, 8 ACK
	int         byteIdx;
	logic [7:0] shift;

	// Bus sampled on the system clock, so edges are seen one cycle late
	always @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			sdaPull    <= 1'b0;
			sclQ       = 1'b1;
			sdaQ       = 1'b1;
			inXfer     = 1'b0;
			bitCnt     = 0;
			byteIdx    = 0;
			shift      = '0;
			wrCnt      = 0;
			startCnt   = 0;
			stopCnt    = 0;
			ruleErrCnt = 0;
		end
		else
		begin
			if (sclQ && scl && sdaQ && !sda)
			begin
				// START
				if (inXfer)
					ruleErrCnt++;              // Repeated START not part of this bus
				inXfer   = 1'b1;
				startCnt++;
				bitCnt   = 0;
				byteIdx  = 0;
				wrCnt    = 0;
				sdaPull <= 1'b0;
			end
			else if (sclQ && scl && !sdaQ && sda)
			begin
				// STOP only legal in the pulse after an ACK slot
				if (!inXfer || bitCnt != 1)
					ruleErrCnt++;
				inXfer   = 1'b0;
				stopCnt++;
				sdaPull <= 1'b0;
			end
			else if (!sclQ && scl && inXfer)
			begin
				if (bitCnt < 8)
					shift = {shift[6:0], sda};  // MSB first
				if (bitCnt == 7 && !readMask[byteIdx])
				begin
					wrLog[wrCnt] = shift;
					wrCnt++;
				end
				if (bitCnt == 8)
				begin
					ackLog[byteIdx] = !sda;    // Master ACK is SDA low
					byteIdx++;
					bitCnt = 0;
				end
				else
					bitCnt++;
			end
			else if (sclQ && !scl && inXfer)
				// Next slot of a read byte goes out right after SCL falls
				sdaPull <= readMask[byteIdx] && (bitCnt < 8)
					&& !rdTable[byteIdx * 8 + 7 - bitCnt];
			sclQ = scl;
			sdaQ = sda;
		end
	end

endmodule

// ==== dv/i2cTb.sv ====
// I2C master testbench: clock, reset, APB tasks, compare tasks, directed tests, timeout
`timescale 1ns/1ps

module i2cTb;
	import i2cPkg::*;

	localparam int fifoDepth   = 16;
	localparam int sdaHoldCyc  = 35;
	localparam int stopHoldCyc = 250;
	localparam int divVal      = 50;               // Above sdaHoldCyc, 2 ticks per bit
	localparam int numXfer     = 5;
	localparam int totalBytes  = 4 + 4 + 2 + 2 + fifoDepth + 2;
	// Two divider periods per bit, START and STOP periods plus hold, then margin
	localparam int cycleLimit  = 2 * (totalBytes * 9 * 2 * divVal
		+ numXfer * (3 * divVal + stopHoldCyc)) + 5000;

	logic         iSysClk = 1'b0;
	logic         arstN;
	apbReqT       apbReq;
	apbRspT       apbRsp;
	logic         irq;
	logic         scl;
	logic         sdaOe;
	logic         sdaLine;
	logic         slvPull;
	logic [31:0]  readMask;
	logic [255:0] rdTable;
	int           seed;
	int           errCnt   = 0;
	int           checkCnt = 0;
	int           cycles   = 0;

	always #5 iSysClk = ~iSysClk;                   // 10 ns

	assign sdaLine = ~(sdaOe | slvPull);           // Wired-AND bus

	i2cTop #(
		.fifoDepth   (fifoDepth),
		.sdaHoldCyc  (sdaHoldCyc),
		.stopHoldCyc (stopHoldCyc)
	) i_i2cTop (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.irq     (irq),
		.scl     (scl),
		.sdaOe   (sdaOe),
		.sda     (sdaLine)
	);

	i2cSlaveModel i_i2cSlaveModel (
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.scl      (scl),
		.sda      (sdaLine),
		.readMask (readMask),
		.rdTable  (rdTable),
		.sdaPull  (slvPull)
	);

	always @(posedge iSysClk)
	begin
		cycles <= cycles + 1;
		if (cycles == cycleLimit)
		begin
			$display("Timeout: no finish within %0d clock cycles", cycleLimit);
			$display("tests failed");
			$finish;
		end
	end

	// --------------------
	// APB access
	// --------------------
	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge iSysClk);
		apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge iSysClk);
		apbReq.penable <= 1'b1;                    // Access phase
		@(negedge iSysClk);
		while (!apbRsp.pready)
			@(negedge iSysClk);
		err = apbRsp.pslverr;
		@(posedge iSysClk);
		apbReq <= '0;
	endtask

	task automatic readReg(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge iSysClk);
		apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge iSysClk);
		apbReq.penable <= 1'b1;
		@(negedge iSysClk);
		while (!apbRsp.pready)
			@(negedge iSysClk);
		data = apbRsp.prdata;                      // Rx pop data valid in access cycle
		err  = apbRsp.pslverr;
		@(posedge iSysClk);
		apbReq <= '0;
	endtask

	// --------------------
	// Compare tasks
	// --------------------
	task automatic expectBit(input string what, input logic got, input logic exp);
		checkCnt++;
		if (got !== exp)
		begin
			errCnt++;
			$display("FAIL %0t: %s got %b exp %b", $time, what, got, exp);
		end
	endtask

	task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
		checkCnt++;
		if (got !== exp)
		begin
			errCnt++;
			$display("FAIL %0t: %s got %h exp %h", $time, what, got, exp);
		end
	endtask

	task automatic checkRx(input string what, input rxItemT got, input rxItemT exp);
		checkCnt++;
		if (got !== exp)
		begin
			errCnt++;
			$display("FAIL %0t: %s got index %0d data %h exp index %0d data %h", $time, what,
				got.index, got.data, exp.index, exp.data);
		end
	endtask

	task automatic checkStatus(input string what, input logic [31:0] got, input logic expBusy,
		input logic expDone, input logic expOvf, input int expTx, input int expRx);
		logic [31:0] exp;
		exp                    = '0;
		exp[statBusyBit]       = expBusy;
		exp[statDoneBit]       = expDone;
		exp[statOvfBit]        = expOvf;
		exp[statTxLvlLsb +: 8] = 8'(expTx);
		exp[statRxLvlLsb +: 8] = 8'(expRx);
		checkCnt++;
		if ((got & 32'h00FF_FF07) !== exp)         // Defined status fields only
		begin
			errCnt++;
			$display("FAIL %0t: %s got %h exp %h", $time, what, got & 32'h00FF_FF07, exp);
		end
	endtask

	task automatic endTest(input string name, input int e0);
		if (errCnt == e0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errCnt - e0);
	endtask

	// --------------------
	// Transaction helpers
	// --------------------
	task automatic loadTx(input logic readDir, input logic [7:0] data);
		logic err;
		writeReg(regTxData, {23'd0, readDir, data}, err);
		expectBit("tx push error", err, 1'b0);
	endtask

	task automatic startXfer(input logic [7:0] len, input logic intEn);
		logic err;
		writeReg(regCtrl, {15'd0, intEn, len, 7'd0, 1'b1}, err);
		expectBit("start error", err, 1'b0);
	endtask

	task automatic waitDone(output logic [31:0] w);
		logic err;
		w = '0;
		while (!w[statDoneBit])                    // Bounded by the cycle timeout
			readReg(regStatus, w, err);
	endtask

	task automatic clearSticky();
		logic err;
		writeReg(regStatus, (32'd1 << statDoneBit) | (32'd1 << statOvfBit), err);
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic resetState();
		int          e0;
		logic [31:0] w;
		logic        err;
		e0 = errCnt;
		@(negedge iSysClk);
		expectBit("scl after reset", scl, 1'b1);
		expectBit("sdaOe after reset", sdaOe, 1'b0);
		expectBit("irq after reset", irq, 1'b0);
		expectBit("pready after reset", apbRsp.pready, 1'b0);
		readReg(regStatus, w, err);
		checkStatus("status after reset", w, 1'b0, 1'b0, 1'b0, 0, 0);
		endTest("reset state", e0);
	endtask

	task automatic writeXfer();
		int          e0;
		int          s0;
		int          p0;
		int          k;
		logic [7:0]  bytes [4];
		logic [31:0] w;
		logic        err;
		e0 = errCnt;
		s0 = i_i2cSlaveModel.startCnt;
		p0 = i_i2cSlaveModel.stopCnt;
		readMask <= '0;
		for (k = 0; k < 4; k++)
		begin
			bytes[k] = 8'($random(seed));
			loadTx(1'b0, bytes[k]);
		end
		readReg(regStatus, w, err);
		checkStatus("status loaded", w, 1'b0, 1'b0, 1'b0, 4, 0);
		startXfer(8'd4, 1'b1);
		waitDone(w);
		checkStatus("status after write", w, 1'b0, 1'b1, 1'b0, 0, 0);
		@(negedge iSysClk);
		expectBit("irq on done", irq, 1'b1);
		checkByte("bytes logged", 8'(i_i2cSlaveModel.wrCnt), 8'd4);
		for (k = 0; k < 4; k++)
			checkByte("written byte", i_i2cSlaveModel.wrLog[k], bytes[k]);
		checkByte("START count", 8'(i_i2cSlaveModel.startCnt - s0), 8'd1);
		checkByte("STOP count", 8'(i_i2cSlaveModel.stopCnt - p0), 8'd1);
		clearSticky();
		endTest("write transaction", e0);
	endtask

	task automatic mixedDir();
		int          e0;
		int          k;
		logic [7:0]  wb;
		logic [31:0] w;
		logic        err;
		rxItemT      expItem;
		e0 = errCnt;
		wb = 8'($random(seed));
		readMask <= 32'h0000_000E;                 // Bytes 1..3 from slave
		loadTx(1'b0, wb);
		for (k = 0; k < 3; k++)
			loadTx(1'b1, 8'h00);
		startXfer(8'd4, 1'b0);
		waitDone(w);
		checkStatus("status after mixed", w, 1'b0, 1'b1, 1'b0, 0, 3);
		checkByte("write byte", i_i2cSlaveModel.wrLog[0], wb);
		for (k = 1; k < 4; k++)
		begin
			readReg(regRxData, w, err);
			expectBit("rx pop error", err, 1'b0);
			expItem = '{index: 8'(k), data: rdTable[k * 8 +: 8]};
			checkRx("rx item", rxItemT'(w[15:0]), expItem);
			expectBit("master ACK low", i_i2cSlaveModel.ackLog[k], 1'b1);
		end
		clearSticky();
		endTest("mixed direction", e0);
	endtask

	task automatic busRule();
		int          e0;
		int          r0;
		int          s0;
		int          p0;
		logic [31:0] w;
		logic        err;
		rxItemT      expItem;
		e0 = errCnt;
		r0 = i_i2cSlaveModel.ruleErrCnt;
		s0 = i_i2cSlaveModel.startCnt;
		p0 = i_i2cSlaveModel.stopCnt;
		readMask <= 32'h0000_0002;
		loadTx(1'b0, 8'($random(seed)));
		loadTx(1'b1, 8'h00);
		startXfer(8'd2, 1'b0);
		waitDone(w);
		checkByte("SDA rule flags", 8'(i_i2cSlaveModel.ruleErrCnt - r0), 8'd0);
		checkByte("START count", 8'(i_i2cSlaveModel.startCnt - s0), 8'd1);
		checkByte("STOP count", 8'(i_i2cSlaveModel.stopCnt - p0), 8'd1);
		readReg(regRxData, w, err);
		expItem = '{index: 8'd1, data: rdTable[15:8]};
		checkRx("rx item", rxItemT'(w[15:0]), expItem);
		clearSticky();
		endTest("bus rule", e0);
	endtask

	task automatic errorCases();
		int          e0;
		int          s0;
		logic [7:0]  b0;
		logic [7:0]  b1;
		logic [31:0] w;
		logic        err;
		e0 = errCnt;
		s0 = i_i2cSlaveModel.startCnt;
		b0 = 8'($random(seed));
		b1 = 8'($random(seed));
		readMask <= '0;
		loadTx(1'b0, b0);
		loadTx(1'b0, b1);
		startXfer(8'd2, 1'b1);
		writeReg(regCtrl, {15'd0, 1'b0, 8'd5, 7'd0, 1'b1}, err);   // Second start, engine busy
		expectBit("start while busy error", err, 1'b1);
		waitDone(w);
		checkStatus("status after busy start", w, 1'b0, 1'b1, 1'b0, 0, 0);
		checkByte("bytes logged", 8'(i_i2cSlaveModel.wrCnt), 8'd2);
		checkByte("first byte", i_i2cSlaveModel.wrLog[0], b0);
		checkByte("second byte", i_i2cSlaveModel.wrLog[1], b1);
		checkByte("START count", 8'(i_i2cSlaveModel.startCnt - s0), 8'd1);
		@(negedge iSysClk);
		expectBit("irq kept enabled", irq, 1'b1);
		readReg(regRxData, w, err);
		expectBit("empty rx read error", err, 1'b1);
		checkByte("empty rx data", w[7:0], 8'h00);
		writeReg(regStatus, 32'd1 << statDoneBit, err);
		readReg(regStatus, w, err);
		checkStatus("done cleared", w, 1'b0, 1'b0, 1'b0, 0, 0);
		@(negedge iSysClk);
		expectBit("irq after clear", irq, 1'b0);
		endTest("errors and stickiness", e0);
	endtask

	task automatic rxOverflow();
		int          e0;
		int          k;
		int          pushed;
		int          nRd;
		logic [31:0] w;
		logic        err;
		rxItemT      expItem;
		e0  = errCnt;
		nRd = fifoDepth + 2;
		readMask <= (32'd1 << nRd) - 32'd1;
		for (k = 0; k < fifoDepth; k++)
			loadTx(1'b1, 8'h00);
		startXfer(8'(nRd), 1'b0);
		// Top up the tx FIFO as the engine drains it
		pushed = fifoDepth;
		while (pushed < nRd)
		begin
			readReg(regStatus, w, err);
			if (w[statTxLvlLsb +: 8] < 8'(fifoDepth))
			begin
				loadTx(1'b1, 8'h00);
				pushed++;
			end
		end
		waitDone(w);
		checkStatus("status after overflow", w, 1'b0, 1'b1, 1'b1, 0, fifoDepth);
		for (k = 0; k < fifoDepth; k++)
		begin
			readReg(regRxData, w, err);
			expItem = '{index: 8'(k), data: rdTable[k * 8 +: 8]};
			checkRx("kept rx item", rxItemT'(w[15:0]), expItem);
		end
		readReg(regStatus, w, err);
		checkStatus("rx drained", w, 1'b0, 1'b1, 1'b1, 0, 0);
		clearSticky();
		endTest("rx overflow", e0);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		int   k;
		logic err;
		seed = 32'h0c098f5d;
		arstN    <= 1'b0;
		apbReq   <= '0;
		readMask <= '0;
		for (k = 0; k < 32; k++)
			rdTable[k * 8 +: 8] = 8'($random(seed));   // Slave read data
		repeat (5) @(posedge iSysClk);
		arstN <= 1'b1;
		@(posedge iSysClk);
		resetState();
		writeReg(regDiv, 32'(divVal), err);
		writeXfer();
		mixedDir();
		busRule();
		errorCases();
		rxOverflow();
		$display("checks: %0d, errors: %0d", checkCnt, errCnt);
		if (errCnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== flist.f ====
hw/i2cPkg.sv
hw/i2cApbRegs.sv
hw/i2cSyncFifo.sv
hw/i2cClkDiv.sv
hw/i2cByteEngine.sv
hw/i2cTop.sv
dv/i2cSlaveModel.sv
dv/i2cTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the I2C master testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module i2cTb -f flist.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
